//--- bench/video_golden.hex
// Words 0-31: palette load, top 3 hex digits address {bank, dot}, low 3 digits RGB word
// Words 32-47: dot seeds in the low byte, each has a word in both banks
// Bank 0
000F21 0130F4 02700F 03AFF0
04C0FF 055F0F 068888 07F123
081456 096789 0A2ABC 0B5DEF
0C9E1D 0D02C7 0E4B6A 0FFFFF
// Bank 1, same dots, other colours
1001E3 113A05 1275C6 13A07A
14CB18 15529C 168D43 17FE7D
1813B1 196C5E 1A264F 1B59A2
1C9F8B 1D08D9 1E44E0 1FF111
// Dot seeds
000000 000013 000027 00003A 00004C 000055 000068 00007F
000081 000096 0000A2 0000B5 0000C9 0000D0 0000E4 0000FF

//--- src.f
rtl/video_pkg.sv
rtl/sync_pulses.sv
rtl/sync_to_blanking.sv
rtl/blanking_to_count.sv
rtl/palette_lookup.sv
rtl/video_top.sv
bench/video_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= video_tb
DUT_TOP   ?= video_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: run ended without a result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/video_tb.sv
`timescale 1ns/1ns

module video_tb;

	// Small raster keeps a frame under a thousand cycles
	localparam int TOTAL_COLS       = 48;
	localparam int TOTAL_ROWS       = 20;
	localparam int ACTIVE_COLS      = 32;
	localparam int ACTIVE_ROWS      = 12;
	localparam int SYNC_PULSE_HORZ  = 4;
	localparam int SYNC_PULSE_VERT  = 2;
	localparam int FRONT_PORCH_HORZ = 4;
	localparam int BACK_PORCH_HORZ  = 8;
	localparam int FRONT_PORCH_VERT = 2;
	localparam int BACK_PORCH_VERT  = 4;

	localparam int C_W = video_pkg::COLOR_W;
	localparam int D_W = video_pkg::DOT_W;
	localparam int A_W = video_pkg::PAL_ADDR_W;
	localparam int P_W = video_pkg::PAL_DATA_W;
	localparam int N_W = video_pkg::CNT_W;

	// Golden file holds palette words first and dot seeds after
	localparam int PAL_WORDS  = 32;
	localparam int SEED_WORDS = 16;

	localparam int RESET_CYCLES = 4;
	localparam int FRAMES       = 3;
	localparam int FRAME_CYCLES = TOTAL_COLS * TOTAL_ROWS;
	// Reset, load, three frames and one spare frame
	localparam int CYCLE_LIMIT  = RESET_CYCLES + PAL_WORDS + 2 + (FRAMES + 1) * FRAME_CYCLES;

	logic           i_clk;
	logic           i_rst_n;
	logic           i_pal_we;
	logic [A_W-1:0] i_pal_addr;
	logic [P_W-1:0] i_pal_data;
	logic [D_W-1:0] i_dot = '0;
	logic           i_bank = 1'b0;
	logic [C_W-1:0] o_red;
	logic [C_W-1:0] o_green;
	logic [C_W-1:0] o_blue;
	logic           o_hsync_n;
	logic           o_vsync_n;
	logic           o_locked;
	logic           o_active;
	logic [N_W-1:0] o_col;
	logic [N_W-1:0] o_row;

	// Golden words and the bench's palette copy
	logic [23:0]    golden [PAL_WORDS + SEED_WORDS];
	logic [P_W-1:0] pal_model [2**A_W];
	bit             pal_loaded [2**A_W];
	logic [D_W-1:0] seeds [SEED_WORDS];

	// Colour due at the next falling edge
	logic [P_W-1:0] exp_rgb = '0;

	int  errors = 0;
	int  checks = 0;
	int  cyc = 0;
	bit  running = 1'b0;
	int  frames_done = 0;
	int  bank0_dots = 0;
	int  bank1_dots = 0;

	// Sync tracking
	bit  hs_prev = 1'b1;
	bit  vs_prev = 1'b1;
	int  hs_fall_cyc = -1;
	int  vs_fall_cyc = -1;
	int  hs_low = 0;
	int  vs_low = 0;

	// Raster tracking
	bit  act_prev = 1'b0;
	bit  act_prev2 = 1'b0;
	bit  first_line_seen = 1'b0;
	bit  lock_seen = 1'b0;
	int  lock_cyc = -1;
	int  col_exp = 0;
	int  row_exp = 0;
	int  run_len = 0;
	int  frame_lines = 0;

	video_top #(
		.TOTAL_COLS       (TOTAL_COLS),
		.TOTAL_ROWS       (TOTAL_ROWS),
		.ACTIVE_COLS      (ACTIVE_COLS),
		.ACTIVE_ROWS      (ACTIVE_ROWS),
		.SYNC_PULSE_HORZ  (SYNC_PULSE_HORZ),
		.SYNC_PULSE_VERT  (SYNC_PULSE_VERT),
		.FRONT_PORCH_HORZ (FRONT_PORCH_HORZ),
		.BACK_PORCH_HORZ  (BACK_PORCH_HORZ),
		.FRONT_PORCH_VERT (FRONT_PORCH_VERT),
		.BACK_PORCH_VERT  (BACK_PORCH_VERT)
	) dut (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_pal_we   (i_pal_we),
		.i_pal_addr (i_pal_addr),
		.i_pal_data (i_pal_data),
		.i_dot      (i_dot),
		.i_bank     (i_bank),
		.o_red      (o_red),
		.o_green    (o_green),
		.o_blue     (o_blue),
		.o_hsync_n  (o_hsync_n),
		.o_vsync_n  (o_vsync_n),
		.o_locked   (o_locked),
		.o_active   (o_active),
		.o_col      (o_col),
		.o_row      (o_row)
	);

	// 4 ns pixel clock
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare and report
	////////////////////////////////////////////////////////////////////////////

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task report_failure(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// Palette copy and seed table from the golden words
	task build_model();
		int i;
		for (i = 0; i < PAL_WORDS; i++) begin
			pal_model[golden[i][12 +: A_W]]  = golden[i][0 +: P_W];
			pal_loaded[golden[i][12 +: A_W]] = 1'b1;
		end
		for (i = 0; i < SEED_WORDS; i++) begin
			seeds[i] = golden[PAL_WORDS + i][0 +: D_W];
			// Every seed needs a distinct word in each bank
			if (!pal_loaded[{1'b0, seeds[i]}] || !pal_loaded[{1'b1, seeds[i]}]) begin
				report_failure($sformatf("golden file lacks a palette word for dot %0h",
					seeds[i]));
			end else if (pal_model[{1'b0, seeds[i]}] == pal_model[{1'b1, seeds[i]}]) begin
				report_failure($sformatf("golden file gives dot %0h one colour in both banks",
					seeds[i]));
			end
		end
	endtask

	task check_reset_values();
		check_value("o_red", 32'(o_red), 32'(0));
		check_value("o_green", 32'(o_green), 32'(0));
		check_value("o_blue", 32'(o_blue), 32'(0));
		check_value("o_active", 32'(o_active), 32'(0));
		check_value("o_locked", 32'(o_locked), 32'(0));
		check_value("o_hsync_n", 32'(o_hsync_n), 32'(1));
		check_value("o_vsync_n", 32'(o_vsync_n), 32'(1));
	endtask

	// One write strobe per golden palette word
	task load_palette();
		int i;
		for (i = 0; i < PAL_WORDS; i++) begin
			@(negedge i_clk);
			i_pal_we   = 1'b1;
			i_pal_addr = golden[i][12 +: A_W];
			i_pal_data = golden[i][0 +: P_W];
		end
		@(negedge i_clk);
		i_pal_we = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle checks on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task check_colour();
		check_value("o_red", 32'(o_red), 32'(exp_rgb[3*C_W-1:2*C_W]));
		check_value("o_green", 32'(o_green), 32'(exp_rgb[2*C_W-1:C_W]));
		check_value("o_blue", 32'(o_blue), 32'(exp_rgb[C_W-1:0]));
	endtask

	task check_syncs();
		// Hsync width and line period
		if (hs_prev && !o_hsync_n) begin
			if (hs_fall_cyc >= 0) begin
				check_value("o_hsync_n period", 32'(cyc - hs_fall_cyc), 32'(TOTAL_COLS));
			end else begin
				// First line is long before vblank ends
				check_value("o_locked", 32'(o_locked), 32'(0));
			end
			hs_fall_cyc = cyc;
			hs_low      = 0;
		end
		if (!o_hsync_n) begin
			hs_low++;
		end
		if (!hs_prev && o_hsync_n && hs_fall_cyc >= 0) begin
			check_value("o_hsync_n low cycles", 32'(hs_low), 32'(SYNC_PULSE_HORZ));
		end

		// Vsync width and frame period in pixel cycles
		if (vs_prev && !o_vsync_n) begin
			if (vs_fall_cyc >= 0) begin
				check_value("o_vsync_n period", 32'(cyc - vs_fall_cyc), 32'(FRAME_CYCLES));
				check_value("active lines", 32'(frame_lines), 32'(ACTIVE_ROWS));
				frames_done++;
			end
			vs_fall_cyc = cyc;
			vs_low      = 0;
			frame_lines = 0;
		end
		if (!o_vsync_n) begin
			vs_low++;
		end
		if (!vs_prev && o_vsync_n && vs_fall_cyc >= 0) begin
			check_value("o_vsync_n low cycles", 32'(vs_low),
				32'(SYNC_PULSE_VERT * TOTAL_COLS));
		end

		hs_prev = o_hsync_n;
		vs_prev = o_vsync_n;
	endtask

	task check_raster();
		// Sticky lock
		if (lock_seen && !o_locked) begin
			report_failure("o_locked dropped after going high");
		end
		if (o_locked && !lock_seen) begin
			lock_seen = 1'b1;
			lock_cyc  = cyc;
		end

		// New active line
		if (o_active && !act_prev) begin
			col_exp = 0;
			row_exp = frame_lines;
			run_len = 0;
			frame_lines++;
			// Lock comes with vblank fall one back porch ahead of the first dot
			if (!first_line_seen) begin
				first_line_seen = 1'b1;
				check_value("o_locked lead", 32'(cyc - lock_cyc),
					32'(SYNC_PULSE_HORZ + BACK_PORCH_HORZ));
			end
		end

		if (o_active) begin
			check_value("o_col", 32'(o_col), 32'(col_exp));
			check_value("o_row", 32'(o_row), 32'(row_exp));
			col_exp++;
			run_len++;
		end else begin
			check_value("o_col", 32'(o_col), 32'(0));
			check_value("o_row", 32'(o_row), 32'(0));
		end

		if (!o_active && act_prev) begin
			check_value("o_active high cycles", 32'(run_len), 32'(ACTIVE_COLS));
		end

		// Active one cycle late lines up with the output hsync
		if (act_prev && !act_prev2) begin
			check_value("o_active start", 32'(cyc - hs_fall_cyc),
				32'(SYNC_PULSE_HORZ + BACK_PORCH_HORZ));
		end

		act_prev2 = act_prev;
		act_prev  = o_active;
	endtask

	// Stand-in for the tile and sprite mixer
	task drive_dot();
		int idx;
		if (o_active) begin
			// Dot from seed table walked by column plus three times row
			idx    = (int'(o_col) + 3 * int'(o_row)) % SEED_WORDS;
			i_dot  = seeds[idx];
			// Lower half of the frame uses bank 1
			i_bank = (int'(o_row) >= ACTIVE_ROWS / 2);
			exp_rgb = pal_model[{i_bank, i_dot}];
			if (i_bank) begin
				bank1_dots++;
			end else begin
				bank0_dots++;
			end
		end else begin
			// Output stays black for any dot in blanking
			i_dot   = D_W'($urandom);
			i_bank  = 1'($urandom);
			exp_rgb = '0;
		end
	endtask

	always @(negedge i_clk) begin
		if (running) begin
			cyc++;
			check_colour();
			check_syncs();
			check_raster();
			drive_dot();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(3));
		i_rst_n    = 1'b0;
		i_pal_we   = 1'b0;
		i_pal_addr = '0;
		i_pal_data = '0;

		$readmemh("bench/video_golden.hex", golden);
		build_model();

		repeat (RESET_CYCLES) @(negedge i_clk);
		check_reset_values();
		i_rst_n = 1'b1;
		@(posedge i_clk);
		running = 1'b1;

		// Palette in well before the first active line
		load_palette();

		while (frames_done < FRAMES && cyc < CYCLE_LIMIT) begin
			@(posedge i_clk);
		end
		if (frames_done < FRAMES) begin
			report_failure($sformatf("timeout after %0d cycles with %0d of %0d frames",
				cyc, frames_done, FRAMES));
		end
		if (bank0_dots == 0 || bank1_dots == 0) begin
			report_failure("active dots did not reach both palette banks");
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- rtl/video_top.sv
`timescale 1ns/1ns

module video_top #(
	parameter int TOTAL_COLS       = 384,
	parameter int TOTAL_ROWS       = 288,
	parameter int ACTIVE_COLS      = 288,
	parameter int ACTIVE_ROWS      = 224,
	parameter int SYNC_PULSE_HORZ  = 32,
	parameter int SYNC_PULSE_VERT  = 8,
	parameter int FRONT_PORCH_HORZ = 32,
	parameter int BACK_PORCH_HORZ  = 32,
	parameter int FRONT_PORCH_VERT = 48,
	parameter int BACK_PORCH_VERT  = 8
) (
	input  logic                              i_clk,
	input  logic                              i_rst_n,
	input  logic                              i_pal_we,
	input  logic [video_pkg::PAL_ADDR_W-1:0] i_pal_addr,
	input  logic [video_pkg::PAL_DATA_W-1:0] i_pal_data,
	input  logic [video_pkg::DOT_W-1:0]      i_dot,
	input  logic                              i_bank,
	output logic [video_pkg::COLOR_W-1:0]    o_red,
	output logic [video_pkg::COLOR_W-1:0]    o_green,
	output logic [video_pkg::COLOR_W-1:0]    o_blue,
	output logic                              o_hsync_n,
	output logic                              o_vsync_n,
	output logic                              o_locked,
	output logic                              o_active,
	output logic [video_pkg::CNT_W-1:0]      o_col,
	output logic [video_pkg::CNT_W-1:0]      o_row
);

	// Stage 1 syncs, straight from the counters
	logic hsync_1_n;
	logic vsync_1_n;

	// Stage 2 syncs and recovered blanking
	logic hsync_2_n;
	logic vsync_2_n;
	logic hblank_2;
	logic vblank_2;

	// Stage 3 syncs, aligned with the active counts
	logic hsync_3_n;
	logic vsync_3_n;

	////////////////////////////////////////////////////////////////////////////
	// Raster timing chain
	////////////////////////////////////////////////////////////////////////////

	sync_pulses #(
		.TOTAL_COLS      (TOTAL_COLS),
		.TOTAL_ROWS      (TOTAL_ROWS),
		.SYNC_PULSE_HORZ (SYNC_PULSE_HORZ),
		.SYNC_PULSE_VERT (SYNC_PULSE_VERT)
	) u_sync_pulses (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.o_hsync_n (hsync_1_n),
		.o_vsync_n (vsync_1_n)
	);

	sync_to_blanking #(
		.ACTIVE_COLS      (ACTIVE_COLS),
		.ACTIVE_ROWS      (ACTIVE_ROWS),
		.SYNC_PULSE_HORZ  (SYNC_PULSE_HORZ),
		.SYNC_PULSE_VERT  (SYNC_PULSE_VERT),
		.FRONT_PORCH_HORZ (FRONT_PORCH_HORZ),
		.BACK_PORCH_HORZ  (BACK_PORCH_HORZ),
		.FRONT_PORCH_VERT (FRONT_PORCH_VERT),
		.BACK_PORCH_VERT  (BACK_PORCH_VERT)
	) u_sync_to_blanking (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_hsync_n (hsync_1_n),
		.i_vsync_n (vsync_1_n),
		.o_hsync_n (hsync_2_n),
		.o_vsync_n (vsync_2_n),
		.o_hblank  (hblank_2),
		.o_vblank  (vblank_2)
	);

	blanking_to_count #(
		.ACTIVE_COLS (ACTIVE_COLS),
		.ACTIVE_ROWS (ACTIVE_ROWS)
	) u_blanking_to_count (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_hsync_n (hsync_2_n),
		.i_vsync_n (vsync_2_n),
		.i_hblank  (hblank_2),
		.i_vblank  (vblank_2),
		.o_locked  (o_locked),
		.o_active  (o_active),
		.o_hsync_n (hsync_3_n),
		.o_vsync_n (vsync_3_n),
		.o_col     (o_col),
		.o_row     (o_row)
	);

	// Colour lookup, one more cycle on the syncs
	palette_lookup u_palette_lookup (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_pal_we   (i_pal_we),
		.i_pal_addr (i_pal_addr),
		.i_pal_data (i_pal_data),
		.i_dot      (i_dot),
		.i_bank     (i_bank),
		.i_active   (o_active),
		.i_hsync_n  (hsync_3_n),
		.i_vsync_n  (vsync_3_n),
		.o_red      (o_red),
		.o_green    (o_green),
		.o_blue     (o_blue),
		.o_hsync_n  (o_hsync_n),
		.o_vsync_n  (o_vsync_n)
	);

endmodule

//--- rtl/palette_lookup.sv
`timescale 1ns/1ns

module palette_lookup (
	input  logic                              i_clk,
	input  logic                              i_rst_n,
	input  logic                              i_pal_we,
	input  logic [video_pkg::PAL_ADDR_W-1:0] i_pal_addr,
	input  logic [video_pkg::PAL_DATA_W-1:0] i_pal_data,
	input  logic [video_pkg::DOT_W-1:0]      i_dot,
	input  logic                              i_bank,
	input  logic                              i_active,
	input  logic                              i_hsync_n,
	input  logic                              i_vsync_n,
	output logic [video_pkg::COLOR_W-1:0]    o_red,
	output logic [video_pkg::COLOR_W-1:0]    o_green,
	output logic [video_pkg::COLOR_W-1:0]    o_blue,
	output logic                              o_hsync_n,
	output logic                              o_vsync_n
);

	localparam int C = video_pkg::COLOR_W;

	// Two banks of 256 entries, stands in for the colour PROMs
	logic [video_pkg::PAL_DATA_W-1:0] mem [2**video_pkg::PAL_ADDR_W];

	// Looked-up word and its active flag
	logic [video_pkg::PAL_DATA_W-1:0] rd_q;
	logic                              act_q;

	// Write and read share the edge, read sees the old word
	always_ff @(posedge i_clk) begin
		if (i_pal_we) begin
			mem[i_pal_addr] <= i_pal_data;
		end
		rd_q <= mem[{i_bank, i_dot}];
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			act_q     <= 1'b0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
		end else begin
			act_q     <= i_active;
			// Syncs follow the colour latency
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Component split, black in blanking
	////////////////////////////////////////////////////////////////////////////

	assign o_red   = act_q ? rd_q[3*C-1:2*C] : '0;
	assign o_green = act_q ? rd_q[2*C-1:C]   : '0;
	assign o_blue  = act_q ? rd_q[C-1:0]     : '0;

endmodule

//--- rtl/blanking_to_count.sv
`timescale 1ns/1ns

module blanking_to_count #(
	parameter int ACTIVE_COLS = 288,
	parameter int ACTIVE_ROWS = 224
) (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_hsync_n,
	input  logic                         i_vsync_n,
	input  logic                         i_hblank,
	input  logic                         i_vblank,
	output logic                         o_locked,
	output logic                         o_active,
	output logic                         o_hsync_n,
	output logic                         o_vsync_n,
	output logic [video_pkg::CNT_W-1:0] o_col,
	output logic [video_pkg::CNT_W-1:0] o_row
);

	localparam int W = video_pkg::CNT_W;

	// Counter ceilings
	localparam logic [W-1:0] COL_LAST  = W'(ACTIVE_COLS - 1);
	localparam logic [W-1:0] ROW_LINES = W'(ACTIVE_ROWS);

	// Previous blanking levels for edge detect
	logic hb_q;
	logic vb_q;

	// Active lines started in this frame
	logic [W-1:0] lines;
	logic [W-1:0] lines_nxt;

	logic active_nxt;
	logic h_fall;

	always_comb begin
		active_nxt = ~i_hblank & ~i_vblank;
		// Start of an active line
		h_fall     = hb_q & ~i_hblank;

		// One more line per hblank fall inside the vertical window
		if (i_vblank) begin
			lines_nxt = '0;
		end else if (h_fall && lines != ROW_LINES) begin
			lines_nxt = lines + 1'b1;
		end else begin
			lines_nxt = lines;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hb_q      <= 1'b1;
			vb_q      <= 1'b1;
			lines     <= '0;
			o_locked  <= 1'b0;
			o_active  <= 1'b0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_col     <= '0;
			o_row     <= '0;
		end else begin
			hb_q      <= i_hblank;
			vb_q      <= i_vblank;
			lines     <= lines_nxt;
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
			o_active  <= active_nxt;

			// Sticky once vblank has fallen
			if (vb_q && !i_vblank) begin
				o_locked <= 1'b1;
			end

			// Column from 0 at start of active, 0 outside
			if (!active_nxt || !o_active) begin
				o_col <= '0;
			end else if (o_col != COL_LAST) begin
				o_col <= o_col + 1'b1;
			end

			// Row number is lines started minus one
			o_row <= active_nxt ? lines_nxt - 1'b1 : '0;
		end
	end

endmodule

//--- rtl/sync_to_blanking.sv
`timescale 1ns/1ns

module sync_to_blanking #(
	parameter int ACTIVE_COLS      = 288,
	parameter int ACTIVE_ROWS      = 224,
	parameter int SYNC_PULSE_HORZ  = 32,
	parameter int SYNC_PULSE_VERT  = 8,
	parameter int FRONT_PORCH_HORZ = 32,
	parameter int BACK_PORCH_HORZ  = 32,
	parameter int FRONT_PORCH_VERT = 48,
	parameter int BACK_PORCH_VERT  = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_hsync_n,
	input  logic i_vsync_n,
	output logic o_hsync_n,
	output logic o_vsync_n,
	output logic o_hblank,
	output logic o_vblank
);

	localparam int W = video_pkg::CNT_W;

	// Active window, counted from the sync falling edge
	localparam logic [W-1:0] H_START = W'(SYNC_PULSE_HORZ + BACK_PORCH_HORZ);
	localparam logic [W-1:0] H_STOP  = W'(SYNC_PULSE_HORZ + BACK_PORCH_HORZ + ACTIVE_COLS);
	localparam logic [W-1:0] V_START = W'(SYNC_PULSE_VERT + BACK_PORCH_VERT);
	localparam logic [W-1:0] V_STOP  = W'(SYNC_PULSE_VERT + BACK_PORCH_VERT + ACTIVE_ROWS);

	// Front porch closes the line and the frame
	localparam logic [W-1:0] H_LAST = W'(SYNC_PULSE_HORZ + BACK_PORCH_HORZ + ACTIVE_COLS
		+ FRONT_PORCH_HORZ - 1);
	localparam logic [W-1:0] V_LAST = W'(SYNC_PULSE_VERT + BACK_PORCH_VERT + ACTIVE_ROWS
		+ FRONT_PORCH_VERT - 1);

	// Recovered position, aligned with the output syncs
	logic [W-1:0] col;
	logic [W-1:0] row;
	logic [W-1:0] col_nxt;
	logic [W-1:0] row_nxt;

	// Sync seen at least once since reset
	logic h_seen;
	logic v_seen;
	logic h_seen_nxt;
	logic v_seen_nxt;

	logic h_fall;
	logic v_fall;

	always_comb begin
		// Output sync holds the previous input level
		h_fall     = o_hsync_n & ~i_hsync_n;
		v_fall     = o_vsync_n & ~i_vsync_n;
		h_seen_nxt = h_seen | h_fall;
		v_seen_nxt = v_seen | v_fall;

		// Column restarts on hsync, parks at end of line
		if (h_fall) begin
			col_nxt = '0;
		end else if (col == H_LAST) begin
			col_nxt = col;
		end else begin
			col_nxt = col + 1'b1;
		end

		// Row restarts on vsync, steps once per line
		if (v_fall) begin
			row_nxt = '0;
		end else if (h_fall && row != V_LAST) begin
			row_nxt = row + 1'b1;
		end else begin
			row_nxt = row;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registered syncs and blanking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col       <= '0;
			row       <= '0;
			h_seen    <= 1'b0;
			v_seen    <= 1'b0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
		end else begin
			col       <= col_nxt;
			row       <= row_nxt;
			h_seen    <= h_seen_nxt;
			v_seen    <= v_seen_nxt;
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
			// Blank until locked to the first sync
			o_hblank  <= !(h_seen_nxt && col_nxt >= H_START && col_nxt < H_STOP);
			o_vblank  <= !(v_seen_nxt && row_nxt >= V_START && row_nxt < V_STOP);
		end
	end

endmodule

//--- rtl/sync_pulses.sv
`timescale 1ns/1ns

module sync_pulses #(
	parameter int TOTAL_COLS      = 384,
	parameter int TOTAL_ROWS      = 288,
	parameter int SYNC_PULSE_HORZ = 32,
	parameter int SYNC_PULSE_VERT = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	output logic o_hsync_n,
	output logic o_vsync_n
);

	localparam int W = video_pkg::CNT_W;

	// Last column and row before wrap
	localparam logic [W-1:0] COL_LAST = W'(TOTAL_COLS - 1);
	localparam logic [W-1:0] ROW_LAST = W'(TOTAL_ROWS - 1);

	// First column and row past the sync pulse
	localparam logic [W-1:0] HS_END = W'(SYNC_PULSE_HORZ);
	localparam logic [W-1:0] VS_END = W'(SYNC_PULSE_VERT);

	// Free-running raster position
	logic [W-1:0] col;
	logic [W-1:0] row;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col       <= '0;
			row       <= '0;
			// Both syncs idle high in reset
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
		end else begin
			// Column wrap steps the row
			if (col == COL_LAST) begin
				col <= '0;
				row <= (row == ROW_LAST) ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end

			// Sync low over the first columns / rows
			o_hsync_n <= (col >= HS_END);
			o_vsync_n <= (row >= VS_END);
		end
	end

endmodule

//--- rtl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Colour path widths
	////////////////////////////////////////////////////////////////////////////

	// One colour component, as driven to the resistor DAC
	localparam int COLOR_W = 4;

	// Dot colour index from the tilemap and sprite mixer
	localparam int DOT_W = 8;

	// Palette address is the bank bit on top of the dot index
	localparam int PAL_ADDR_W = DOT_W + 1;

	// Palette word holds red, green, blue from top to bottom
	localparam int PAL_DATA_W = 3 * COLOR_W;

	////////////////////////////////////////////////////////////////////////////
	// Raster timing
	////////////////////////////////////////////////////////////////////////////

	// Column and row counters, wide enough for the full raster
	localparam int CNT_W = 10;

endpackage
